// ==== rtl/motor_pkg.sv ====
/* Brushed DC motor driver shared definitions
   Bus widths, register map, identification word, dead time and drive states */
package motor_pkg;

  // Bus field widths
  localparam int ADDR_W = 3;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] bus_word_t;
  typedef logic [BE_W-1:0]   byte_en_t;

  // Register map, one word per address
  localparam reg_addr_t ADDR_ID     = 3'd0;
  localparam reg_addr_t ADDR_STEP   = 3'd1;
  localparam reg_addr_t ADDR_WIDTH  = 3'd2;
  localparam reg_addr_t ADDR_ENABLE = 3'd3;
  localparam reg_addr_t ADDR_DIR    = 3'd4;

  // Fixed value returned at ADDR_ID
  localparam bus_word_t DRIVER_ID = 32'hEA68_0003;

  // Both legs stay low this many cycles after a reversal
  localparam int DEAD_CYCLES = 4;

  // Counter wide enough to hold DEAD_CYCLES - 1
  localparam int DEAD_CNT_W = (DEAD_CYCLES > 2) ? $clog2(DEAD_CYCLES) : 1;

  typedef logic [DEAD_CNT_W-1:0] dead_cnt_t;

  localparam dead_cnt_t DEAD_LOAD = dead_cnt_t'(DEAD_CYCLES - 1);

  // H-bridge drive state
  typedef enum logic [1:0] {
    DRIVE_OFF  = 2'd0,
    DRIVE_FWD  = 2'd1,
    DRIVE_REV  = 2'd2,
    DRIVE_DEAD = 2'd3
  } drive_state_t;

endpackage

// ==== rtl/motor_regs.sv ====
/* Motor driver register block
   Byte-enabled bus writes, registered read data and the control outputs */
`timescale 1ns/1ps

module motor_regs (
  input  logic                 csi_MCLK_clk,
  input  logic                 rst,
  input  motor_pkg::reg_addr_t avs_ctrl_address,
  input  logic                 avs_ctrl_write,
  input  motor_pkg::bus_word_t avs_ctrl_writedata,
  input  motor_pkg::byte_en_t  avs_ctrl_byteenable,
  output motor_pkg::bus_word_t avs_ctrl_readdata,
  output motor_pkg::bus_word_t pwm_step,
  output motor_pkg::bus_word_t pwm_width,
  output logic                 drive_enable,
  output logic                 drive_forward
);

  motor_pkg::bus_word_t step_q;
  motor_pkg::bus_word_t width_q;
  logic                 enable_q;
  logic                 forward_q;
  motor_pkg::bus_word_t read_q;

  motor_pkg::bus_word_t step_merged;
  motor_pkg::bus_word_t width_merged;
  motor_pkg::bus_word_t read_sel;

  logic wr_step;
  logic wr_width;
  logic wr_enable;
  logic wr_dir;

  // Address decode for writes
  assign wr_step   = avs_ctrl_write && (avs_ctrl_address == motor_pkg::ADDR_STEP);
  assign wr_width  = avs_ctrl_write && (avs_ctrl_address == motor_pkg::ADDR_WIDTH);
  assign wr_enable = avs_ctrl_write && (avs_ctrl_address == motor_pkg::ADDR_ENABLE);
  assign wr_dir    = avs_ctrl_write && (avs_ctrl_address == motor_pkg::ADDR_DIR);

  // Replace only the byte lanes whose enable is set
  always_comb begin
    step_merged  = step_q;
    width_merged = width_q;
    for (int lane = 0; lane < motor_pkg::BE_W; lane++) begin
      if (avs_ctrl_byteenable[lane]) begin
        step_merged[lane*8 +: 8]  = avs_ctrl_writedata[lane*8 +: 8];
        width_merged[lane*8 +: 8] = avs_ctrl_writedata[lane*8 +: 8];
      end
    end
  end

  // Read mux, unused addresses return zero
  always_comb begin
    case (avs_ctrl_address)
      motor_pkg::ADDR_ID:     read_sel = motor_pkg::DRIVER_ID;
      motor_pkg::ADDR_STEP:   read_sel = step_q;
      motor_pkg::ADDR_WIDTH:  read_sel = width_q;
      motor_pkg::ADDR_ENABLE: read_sel = motor_pkg::bus_word_t'(enable_q);
      motor_pkg::ADDR_DIR:    read_sel = motor_pkg::bus_word_t'(forward_q);
      default:                read_sel = '0;
    endcase
  end

  // Control registers
  always_ff @(posedge csi_MCLK_clk) begin
    if (rst) begin
      step_q    <= '0;
      width_q   <= '0;
      enable_q  <= 1'b0;
      forward_q <= 1'b0;
    end else begin
      if (wr_step) begin
        step_q <= step_merged;
      end
      if (wr_width) begin
        width_q <= width_merged;
      end
      // Single-bit registers take bit 0 whatever the byte enables
      if (wr_enable) begin
        enable_q <= avs_ctrl_writedata[0];
      end
      if (wr_dir) begin
        forward_q <= avs_ctrl_writedata[0];
      end
    end
  end

  // Read data refreshes only in cycles without a write
  always_ff @(posedge csi_MCLK_clk) begin
    if (rst) begin
      read_q <= '0;
    end else if (!avs_ctrl_write) begin
      read_q <= read_sel;
    end
  end

  assign avs_ctrl_readdata = read_q;
  assign pwm_step          = step_q;
  assign pwm_width         = width_q;
  assign drive_enable      = enable_q;
  assign drive_forward     = forward_q;

endmodule

// ==== rtl/pwm_engine.sv ====
/* PWM engine
   Phase accumulator with a registered width comparison */
`timescale 1ns/1ps

module pwm_engine (
  input  logic                 csi_MCLK_clk,
  input  logic                 rst,
  input  motor_pkg::bus_word_t pwm_step,
  input  motor_pkg::bus_word_t pwm_width,
  output logic                 pwm_pulse
);

  motor_pkg::bus_word_t phase_acc;
  logic                 pulse_q;
  logic                 below_width;

  // High while the phase has not passed the threshold
  assign below_width = !(phase_acc > pwm_width);

  // The step sets how fast the phase wraps, so it sets the PWM frequency
  always_ff @(posedge csi_MCLK_clk) begin
    if (rst) begin
      phase_acc <= '0;
    end else begin
      phase_acc <= phase_acc + pwm_step;
    end
  end

  // Compare uses the accumulator value from before this edge
  always_ff @(posedge csi_MCLK_clk) begin
    if (rst) begin
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= below_width;
    end
  end

  assign pwm_pulse = pulse_q;

endmodule

// ==== rtl/hbridge_drive.sv ====
/* H-bridge drive stage
   Steers the PWM pulse to one leg and inserts dead time on reversal */
`timescale 1ns/1ps

module hbridge_drive (
  input  logic csi_MCLK_clk,
  input  logic rst,
  input  logic drive_enable,
  input  logic drive_forward,
  input  logic pwm_pulse,
  output logic hx,
  output logic hy
);

  motor_pkg::drive_state_t state;
  motor_pkg::drive_state_t state_next;
  motor_pkg::dead_cnt_t    dead_cnt;
  motor_pkg::dead_cnt_t    dead_cnt_next;

  logic dead_done;

  assign dead_done = (dead_cnt == '0);

  always_comb begin
    state_next    = state;
    dead_cnt_next = dead_cnt;
    if (!drive_enable) begin
      // Disable wins from any state
      state_next    = motor_pkg::DRIVE_OFF;
      dead_cnt_next = '0;
    end else begin
      case (state)
        motor_pkg::DRIVE_OFF: begin
          // Motor was idle, no dead time needed
          state_next = drive_forward ? motor_pkg::DRIVE_FWD : motor_pkg::DRIVE_REV;
        end
        motor_pkg::DRIVE_FWD: begin
          if (!drive_forward) begin
            state_next    = motor_pkg::DRIVE_DEAD;
            dead_cnt_next = motor_pkg::DEAD_LOAD;
          end
        end
        motor_pkg::DRIVE_REV: begin
          if (drive_forward) begin
            state_next    = motor_pkg::DRIVE_DEAD;
            dead_cnt_next = motor_pkg::DEAD_LOAD;
          end
        end
        motor_pkg::DRIVE_DEAD: begin
          if (dead_done) begin
            // Take whatever direction is stored once the gap has elapsed
            state_next = drive_forward ? motor_pkg::DRIVE_FWD : motor_pkg::DRIVE_REV;
          end else begin
            dead_cnt_next = dead_cnt - 1'b1;
          end
        end
        default: begin
          state_next = motor_pkg::DRIVE_OFF;
        end
      endcase
    end
  end

  always_ff @(posedge csi_MCLK_clk) begin
    if (rst) begin
      state    <= motor_pkg::DRIVE_OFF;
      dead_cnt <= '0;
    end else begin
      state    <= state_next;
      dead_cnt <= dead_cnt_next;
    end
  end

  // Each leg carries the pulse only in its own state
  assign hx = (state == motor_pkg::DRIVE_FWD) && pwm_pulse;
  assign hy = (state == motor_pkg::DRIVE_REV) && pwm_pulse;

endmodule

// ==== rtl/brush_motor_driver.sv ====
/* Brushed DC motor driver top level
   Register block, PWM engine and H-bridge drive stage */
`timescale 1ns/1ps

module brush_motor_driver (
  input  logic                 csi_MCLK_clk,
  input  logic                 rst,
  input  motor_pkg::reg_addr_t avs_ctrl_address,
  input  logic                 avs_ctrl_write,
  input  motor_pkg::bus_word_t avs_ctrl_writedata,
  input  motor_pkg::byte_en_t  avs_ctrl_byteenable,
  output motor_pkg::bus_word_t avs_ctrl_readdata,
  output logic                 hx,
  output logic                 hy
);

  motor_pkg::bus_word_t pwm_step;
  motor_pkg::bus_word_t pwm_width;
  logic                 drive_enable;
  logic                 drive_forward;
  logic                 pwm_pulse;

  // Host-facing configuration
  motor_regs motor_regs_i (
    .csi_MCLK_clk        (csi_MCLK_clk),
    .rst                 (rst),
    .avs_ctrl_address    (avs_ctrl_address),
    .avs_ctrl_write      (avs_ctrl_write),
    .avs_ctrl_writedata  (avs_ctrl_writedata),
    .avs_ctrl_byteenable (avs_ctrl_byteenable),
    .avs_ctrl_readdata   (avs_ctrl_readdata),
    .pwm_step            (pwm_step),
    .pwm_width           (pwm_width),
    .drive_enable        (drive_enable),
    .drive_forward       (drive_forward)
  );

  pwm_engine pwm_engine_i (
    .csi_MCLK_clk (csi_MCLK_clk),
    .rst          (rst),
    .pwm_step     (pwm_step),
    .pwm_width    (pwm_width),
    .pwm_pulse    (pwm_pulse)
  );

  // Leg steering with dead time
  hbridge_drive hbridge_drive_i (
    .csi_MCLK_clk  (csi_MCLK_clk),
    .rst           (rst),
    .drive_enable  (drive_enable),
    .drive_forward (drive_forward),
    .pwm_pulse     (pwm_pulse),
    .hx            (hx),
    .hy            (hy)
  );

endmodule

// ==== tests/brush_motor_driver_sva.sv ====
/* Bound assertions for the motor driver
   Read data hold, leg exclusion and leg gating */
`timescale 1ns/1ps

module brush_motor_driver_sva (
  input logic                    csi_MCLK_clk,
  input logic                    rst,
  input logic                    avs_ctrl_write,
  input motor_pkg::bus_word_t    avs_ctrl_readdata,
  input logic                    drive_enable,
  input motor_pkg::drive_state_t drive_state,
  input logic                    hx,
  input logic                    hy
);

  // Read data does not refresh on a write edge
  read_hold: assert property (@(posedge csi_MCLK_clk) disable iff (rst)
    avs_ctrl_write |=> $stable(avs_ctrl_readdata))
    else $error("read data changed after a write cycle");

  legs_exclusive: assert property (@(posedge csi_MCLK_clk) disable iff (rst)
    !(hx && hy))
    else $error("hx and hy high together");

  // State follows the enable one edge later
  legs_low_disabled: assert property (@(posedge csi_MCLK_clk) disable iff (rst)
    !drive_enable |=> (!hx && !hy))
    else $error("leg driven while disabled");

  legs_low_dead: assert property (@(posedge csi_MCLK_clk) disable iff (rst)
    (drive_state == motor_pkg::DRIVE_DEAD) |-> (!hx && !hy))
    else $error("leg driven during dead time");

endmodule

bind brush_motor_driver brush_motor_driver_sva brush_motor_driver_sva_i (
  .csi_MCLK_clk      (csi_MCLK_clk),
  .rst               (rst),
  .avs_ctrl_write    (avs_ctrl_write),
  .avs_ctrl_readdata (avs_ctrl_readdata),
  .drive_enable      (drive_enable),
  .drive_state       (hbridge_drive_i.state),
  .hx                (hx),
  .hy                (hy)
);

// ==== tests/brush_motor_driver_tb.sv ====
/* Brushed DC motor driver testbench
   Table-driven bus stimulus checked against a cycle model of registers, PWM and drive */
`timescale 1ns/1ps

module brush_motor_driver_tb;

  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DELAY = 10;
  localparam int RESET_CYCLES = 10;
  localparam int WATCHDOG_MARGIN = 50;

  typedef struct {
    motor_pkg::reg_addr_t addr;
    logic                 wr;
    motor_pkg::byte_en_t  be;
    motor_pkg::bus_word_t data;
    int                   hold;
    motor_pkg::bus_word_t exp_rd;
  } stim_t;

  logic                 csi_MCLK_clk;
  logic                 rst;
  motor_pkg::reg_addr_t avs_ctrl_address;
  logic                 avs_ctrl_write;
  motor_pkg::bus_word_t avs_ctrl_writedata;
  motor_pkg::byte_en_t  avs_ctrl_byteenable;
  motor_pkg::bus_word_t avs_ctrl_readdata;
  logic                 hx;
  logic                 hy;

  stim_t stim_q[$];
  int    cycle_budget = 0;

  // Reference model state
  motor_pkg::bus_word_t    m_step;
  motor_pkg::bus_word_t    m_width;
  logic                    m_en;
  logic                    m_fwd;
  motor_pkg::bus_word_t    m_rd;
  motor_pkg::bus_word_t    m_acc;
  logic                    m_pulse;
  motor_pkg::drive_state_t m_state;
  int                      dead_left;

  brush_motor_driver brush_motor_driver_i (
    .csi_MCLK_clk        (csi_MCLK_clk),
    .rst                 (rst),
    .avs_ctrl_address    (avs_ctrl_address),
    .avs_ctrl_write      (avs_ctrl_write),
    .avs_ctrl_writedata  (avs_ctrl_writedata),
    .avs_ctrl_byteenable (avs_ctrl_byteenable),
    .avs_ctrl_readdata   (avs_ctrl_readdata),
    .hx                  (hx),
    .hy                  (hy)
  );

  initial begin
    csi_MCLK_clk = 1'b0;
    forever #HALF_PERIOD csi_MCLK_clk = ~csi_MCLK_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic value_mismatch(input string what);
    abort_run($sformatf("CHECK FAILED at %0d ns: %s", $time, what));
  endtask

  // Mask built from the byte enables, one byte per enable bit
  function automatic motor_pkg::bus_word_t merge_lanes(input motor_pkg::bus_word_t old_word,
                                                       input motor_pkg::bus_word_t new_word,
                                                       input motor_pkg::byte_en_t be);
    motor_pkg::bus_word_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic motor_pkg::bus_word_t reg_value(input motor_pkg::reg_addr_t addr);
    case (addr)
      motor_pkg::ADDR_ID:     return motor_pkg::DRIVER_ID;
      motor_pkg::ADDR_STEP:   return m_step;
      motor_pkg::ADDR_WIDTH:  return m_width;
      motor_pkg::ADDR_ENABLE: return {31'd0, m_en};
      motor_pkg::ADDR_DIR:    return {31'd0, m_fwd};
      default:                return '0;
    endcase
  endfunction

  task automatic model_reset();
    m_step    = '0;
    m_width   = '0;
    m_en      = 1'b0;
    m_fwd     = 1'b0;
    m_rd      = '0;
    m_acc     = '0;
    m_pulse   = 1'b0;
    m_state   = motor_pkg::DRIVE_OFF;
    dead_left = 0;
  endtask

  // One clock edge of the model, using the bus inputs seen at that edge
  task automatic model_tick();
    motor_pkg::bus_word_t    n_rd;
    motor_pkg::drive_state_t n_state;
    int                      n_dead;
    n_rd = m_rd;
    if (!avs_ctrl_write) begin
      n_rd = reg_value(avs_ctrl_address);
    end
    n_state = m_state;
    n_dead  = dead_left;
    if (!m_en) begin
      n_state = motor_pkg::DRIVE_OFF;
    end else begin
      case (m_state)
        motor_pkg::DRIVE_OFF: n_state = m_fwd ? motor_pkg::DRIVE_FWD : motor_pkg::DRIVE_REV;
        motor_pkg::DRIVE_FWD: begin
          if (!m_fwd) begin
            n_state = motor_pkg::DRIVE_DEAD;
            n_dead  = motor_pkg::DEAD_CYCLES;
          end
        end
        motor_pkg::DRIVE_REV: begin
          if (m_fwd) begin
            n_state = motor_pkg::DRIVE_DEAD;
            n_dead  = motor_pkg::DEAD_CYCLES;
          end
        end
        motor_pkg::DRIVE_DEAD: begin
          if (dead_left <= 1) begin
            n_state = m_fwd ? motor_pkg::DRIVE_FWD : motor_pkg::DRIVE_REV;
          end else begin
            n_dead = dead_left - 1;
          end
        end
        default: n_state = motor_pkg::DRIVE_OFF;
      endcase
    end
    // Pulse and accumulator see the values from before the edge
    m_pulse = (m_acc <= m_width);
    m_acc   = m_acc + m_step;
    if (avs_ctrl_write) begin
      case (avs_ctrl_address)
        motor_pkg::ADDR_STEP: begin
          m_step = merge_lanes(m_step, avs_ctrl_writedata, avs_ctrl_byteenable);
        end
        motor_pkg::ADDR_WIDTH: begin
          m_width = merge_lanes(m_width, avs_ctrl_writedata, avs_ctrl_byteenable);
        end
        motor_pkg::ADDR_ENABLE: m_en = avs_ctrl_writedata[0];
        motor_pkg::ADDR_DIR:    m_fwd = avs_ctrl_writedata[0];
        default: ;
      endcase
    end
    m_rd      = n_rd;
    m_state   = n_state;
    dead_left = n_dead;
  endtask

  task automatic check_outputs();
    logic exp_hx;
    logic exp_hy;
    exp_hx = (m_state == motor_pkg::DRIVE_FWD) && m_pulse;
    exp_hy = (m_state == motor_pkg::DRIVE_REV) && m_pulse;
    assert (avs_ctrl_readdata === m_rd)
      else value_mismatch($sformatf("readdata %h, model %h", avs_ctrl_readdata, m_rd));
    assert (hx === exp_hx) else value_mismatch($sformatf("hx %b, model %b", hx, exp_hx));
    assert (hy === exp_hy) else value_mismatch($sformatf("hy %b, model %b", hy, exp_hy));
  endtask

  task automatic step_cycle();
    @(posedge csi_MCLK_clk);
    model_tick();
    #DRIVE_DELAY;
    check_outputs();
  endtask

  task automatic add_stim(input motor_pkg::reg_addr_t addr, input logic wr,
                          input motor_pkg::byte_en_t be, input motor_pkg::bus_word_t data,
                          input int hold, input motor_pkg::bus_word_t exp_rd);
    stim_t e;
    e.addr   = addr;
    e.wr     = wr;
    e.be     = be;
    e.data   = data;
    e.hold   = hold;
    e.exp_rd = exp_rd;
    stim_q.push_back(e);
  endtask

  task automatic write_reg(input motor_pkg::reg_addr_t addr, input motor_pkg::byte_en_t be,
                           input motor_pkg::bus_word_t data);
    add_stim(addr, 1'b1, be, data, 1, '0);
  endtask

  task automatic read_reg(input motor_pkg::reg_addr_t addr, input int hold,
                          input motor_pkg::bus_word_t exp_rd);
    add_stim(addr, 1'b0, '0, '0, hold, exp_rd);
  endtask

  task automatic build_table();
    motor_pkg::bus_word_t b_step;
    motor_pkg::bus_word_t b_width;
    motor_pkg::bus_word_t r;
    motor_pkg::byte_en_t  be_list[3];
    b_step  = '0;
    b_width = '0;
    be_list = '{4'b1111, 4'b0001, 4'b1000};
    // Reset values over the whole address range
    for (int a = 0; a < 8; a++) begin
      read_reg(motor_pkg::reg_addr_t'(a), 2, (a == 0) ? motor_pkg::DRIVER_ID : '0);
    end
    foreach (be_list[k]) begin
      r = $urandom;
      write_reg(motor_pkg::ADDR_STEP, be_list[k], r);
      b_step = merge_lanes(b_step, r, be_list[k]);
      read_reg(motor_pkg::ADDR_STEP, 2, b_step);
      r = $urandom;
      write_reg(motor_pkg::ADDR_WIDTH, be_list[k], r);
      b_width = merge_lanes(b_width, r, be_list[k]);
      read_reg(motor_pkg::ADDR_WIDTH, 2, b_width);
    end
    // Read-only and unused addresses ignore writes
    write_reg(motor_pkg::ADDR_ID, 4'hF, $urandom);
    read_reg(motor_pkg::ADDR_ID, 2, motor_pkg::DRIVER_ID);
    for (int a = 5; a < 8; a++) begin
      write_reg(motor_pkg::reg_addr_t'(a), 4'hF, $urandom);
      read_reg(motor_pkg::reg_addr_t'(a), 2, '0);
    end
    read_reg(motor_pkg::ADDR_STEP, 2, b_step);
    read_reg(motor_pkg::ADDR_WIDTH, 2, b_width);
    // Forward run, enable and direction take bit 0 with no byte enables
    write_reg(motor_pkg::ADDR_STEP, 4'hF, $urandom);
    write_reg(motor_pkg::ADDR_WIDTH, 4'hF, $urandom);
    write_reg(motor_pkg::ADDR_DIR, 4'h0, 32'd1);
    write_reg(motor_pkg::ADDR_ENABLE, 4'h0, 32'd1);
    read_reg(motor_pkg::ADDR_ENABLE, 40, 32'd1);
    // Full width keeps the pulse high so every dead cycle shows on the legs
    write_reg(motor_pkg::ADDR_WIDTH, 4'hF, 32'hFFFF_FFFF);
    // Reversal and back
    write_reg(motor_pkg::ADDR_DIR, 4'hF, 32'd0);
    read_reg(motor_pkg::ADDR_DIR, 30, 32'd0);
    write_reg(motor_pkg::ADDR_DIR, 4'hF, 32'd1);
    read_reg(motor_pkg::ADDR_DIR, 20, 32'd1);
    // Disable, change everything, then resume in reverse
    write_reg(motor_pkg::ADDR_ENABLE, 4'hF, 32'hFFFF_FFFE);
    read_reg(motor_pkg::ADDR_ENABLE, 10, 32'd0);
    write_reg(motor_pkg::ADDR_STEP, 4'hF, $urandom);
    write_reg(motor_pkg::ADDR_WIDTH, 4'hF, $urandom);
    write_reg(motor_pkg::ADDR_DIR, 4'hF, 32'd0);
    read_reg(motor_pkg::ADDR_DIR, 6, 32'd0);
    write_reg(motor_pkg::ADDR_ENABLE, 4'hF, 32'd1);
    read_reg(motor_pkg::ADDR_ENABLE, 30, 32'd1);
  endtask

  initial begin
    int total;
    rst                 = 1'b1;
    avs_ctrl_address    = '0;
    avs_ctrl_write      = 1'b0;
    avs_ctrl_writedata  = '0;
    avs_ctrl_byteenable = '0;
    void'($urandom(32'hd41a_f428));
    build_table();
    total = 0;
    foreach (stim_q[i]) begin
      total += stim_q[i].hold;
    end
    cycle_budget = RESET_CYCLES + total + WATCHDOG_MARGIN;
    model_reset();
    repeat (RESET_CYCLES) @(posedge csi_MCLK_clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    foreach (stim_q[i]) begin
      avs_ctrl_address    = stim_q[i].addr;
      avs_ctrl_write      = stim_q[i].wr;
      avs_ctrl_byteenable = stim_q[i].be;
      avs_ctrl_writedata  = stim_q[i].data;
      repeat (stim_q[i].hold) step_cycle();
      if (!stim_q[i].wr) begin
        assert (avs_ctrl_readdata === stim_q[i].exp_rd)
          else value_mismatch($sformatf("entry %0d read %h, table expects %h",
                                        i, avs_ctrl_readdata, stim_q[i].exp_rd));
      end
    end
    $display("Everything OK");
    $finish;
  end

  initial begin : watchdog
    wait (cycle_budget > 0);
    repeat (cycle_budget) @(posedge csi_MCLK_clk);
    abort_run("Watchdog timeout, the stimulus table did not finish in time");
  end

endmodule

// ==== filelist.f ====
rtl/motor_pkg.sv
rtl/motor_regs.sv
rtl/pwm_engine.sv
rtl/hbridge_drive.sv
rtl/brush_motor_driver.sv
tests/brush_motor_driver_sva.sv
tests/brush_motor_driver_tb.sv

// ==== Makefile ====
TOP = brush_motor_driver_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall --top-module brush_motor_driver \
		rtl/motor_pkg.sv rtl/motor_regs.sv rtl/pwm_engine.sv \
		rtl/hbridge_drive.sv rtl/brush_motor_driver.sv

clean:
	rm -rf obj_dir
